// File: lc4_consts.svh
/*
 * LC4 core constants
 * Word width, register count, reset PC and the NOP encoding
 */

`ifndef LC4_CONSTS_SVH
`define LC4_CONSTS_SVH

// Data and address width
`define LC4_WORD_W 16

// Architectural register count
`define LC4_NUM_REGS 8

// First fetch address after reset
`define LC4_RESET_PC 16'h8200

// BR with nzp=000, never taken
`define LC4_NOP_INSN 16'h0000

`endif

// File: lc4_pkg.sv
/*
 * LC4 shared types
 * Word, register select, NZP and the opcode encodings of the kept subset
 */

`include "lc4_consts.svh"

package lc4_pkg;

   // One machine word, data or address
   typedef logic [`LC4_WORD_W-1:0] word_t;

   // Register index
   typedef logic [$clog2(`LC4_NUM_REGS)-1:0] rsel_t;

   // Condition bits, n in bit 2, z in bit 1, p in bit 0
   typedef logic [2:0] nzp_t;

   // Top four bits of the instruction
   typedef enum logic [3:0] {
      OP_BR    = 4'h0,
      OP_ARITH = 4'h1,
      OP_LOGIC = 4'h5,
      OP_LDR   = 4'h6,
      OP_STR   = 4'h7,
      OP_CONST = 4'h9
   } opcode_e;

endpackage

// File: lc4_decoder.sv
/*
 * LC4 instruction decoder
 * Register selects, write enables and class flags for one instruction
 */

`timescale 1ns/1ps

module lc4_decoder (
   input  lc4_pkg::word_t i_insn,
   output lc4_pkg::rsel_t o_r1sel,
   output lc4_pkg::rsel_t o_r2sel,
   output lc4_pkg::rsel_t o_wsel,
   output logic           o_rf_we,
   output logic           o_nzp_we,
   output logic           o_is_load,
   output logic           o_is_store,
   output logic           o_is_branch
);

   lc4_pkg::opcode_e op;

   assign op = lc4_pkg::opcode_e'(i_insn[15:12]);

   always_comb begin
      // Rs always in [8:6], Rd in [11:9]
      o_r1sel     = i_insn[8:6];
      o_r2sel     = i_insn[2:0];
      o_wsel      = i_insn[11:9];
      o_rf_we     = 1'b0;
      o_is_load   = 1'b0;
      o_is_store  = 1'b0;
      o_is_branch = 1'b0;
      case (op)
         lc4_pkg::OP_BR: begin
            o_is_branch = 1'b1;
         end
         lc4_pkg::OP_ARITH: begin
            // ADD 000, SUB 010, ADD imm 1xx; MUL and DIV dropped
            o_rf_we = i_insn[5] || (i_insn[5:3] == 3'b000) || (i_insn[5:3] == 3'b010);
         end
         lc4_pkg::OP_LOGIC: begin
            // AND 000, OR 010, XOR 011; NOT and AND imm dropped
            o_rf_we = !i_insn[5] && (i_insn[4:3] != 2'b01);
         end
         lc4_pkg::OP_LDR: begin
            o_rf_we   = 1'b1;
            o_is_load = 1'b1;
         end
         lc4_pkg::OP_STR: begin
            // Store data register sits where Rd would be
            o_r2sel    = i_insn[11:9];
            o_is_store = 1'b1;
         end
         lc4_pkg::OP_CONST: begin
            o_rf_we = 1'b1;
         end
         default: begin
            // Anything else retires as a NOP
            o_rf_we = 1'b0;
         end
      endcase
      // Every register write also sets NZP
      o_nzp_we = o_rf_we;
   end

endmodule

// File: lc4_alu.sv
/*
 * LC4 ALU
 * Arithmetic, logic, CONST, load/store address and branch target
 */

`timescale 1ns/1ps

module lc4_alu (
   input  lc4_pkg::word_t i_insn,
   input  lc4_pkg::word_t i_pc,
   input  lc4_pkg::word_t i_r1data,
   input  lc4_pkg::word_t i_r2data,
   output lc4_pkg::word_t o_result
);

   lc4_pkg::opcode_e op;
   lc4_pkg::word_t   imm5;
   lc4_pkg::word_t   imm6;
   lc4_pkg::word_t   imm9;

   assign op = lc4_pkg::opcode_e'(i_insn[15:12]);

   // Sign-extended immediates
   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      case (op)
         lc4_pkg::OP_ARITH: begin
            if (i_insn[5])
               o_result = i_r1data + imm5;
            else if (i_insn[4:3] == 2'b10)
               o_result = i_r1data - i_r2data;
            else
               o_result = i_r1data + i_r2data;
         end
         lc4_pkg::OP_LOGIC: begin
            case (i_insn[4:3])
               2'b10:   o_result = i_r1data | i_r2data;
               2'b11:   o_result = i_r1data ^ i_r2data;
               default: o_result = i_r1data & i_r2data;
            endcase
         end
         // Effective address, Rs plus offset
         lc4_pkg::OP_LDR: o_result = i_r1data + imm6;
         lc4_pkg::OP_STR: o_result = i_r1data + imm6;
         lc4_pkg::OP_CONST: o_result = imm9;
         // Target is relative to the next PC
         lc4_pkg::OP_BR: o_result = i_pc + 16'd1 + imm9;
         default: o_result = '0;
      endcase
   end

endmodule

// File: lc4_regfile.sv
/*
 * LC4 register file
 * Eight registers, two read ports, one write port with write-through
 */

`timescale 1ns/1ps

`include "lc4_consts.svh"

module lc4_regfile (
   input  logic           gwe,
   input  logic           i_rst,
   input  lc4_pkg::rsel_t i_rs,
   input  lc4_pkg::rsel_t i_rt,
   input  lc4_pkg::rsel_t i_rd,
   input  lc4_pkg::word_t i_wdata,
   input  logic           i_rd_we,
   output lc4_pkg::word_t o_rs_data,
   output lc4_pkg::word_t o_rt_data
);

   lc4_pkg::word_t regs [`LC4_NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int i = 0; i < `LC4_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Writeback value seen by decode in the same cycle
   assign o_rs_data = (i_rd_we && (i_rs == i_rd)) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_rd_we && (i_rt == i_rd)) ? i_wdata : regs[i_rt];

endmodule

// File: lc4_fetch.sv
/*
 * LC4 fetch stage
 * PC register with branch redirect and the fetch/decode register
 */

`timescale 1ns/1ps

`include "lc4_consts.svh"

module lc4_fetch (
   input  logic           gwe,
   input  logic           i_rst,
   input  logic           i_taken,
   input  lc4_pkg::word_t i_target,
   input  lc4_pkg::word_t i_insn,
   output lc4_pkg::word_t o_pc,
   output lc4_pkg::word_t o_d_insn,
   output lc4_pkg::word_t o_d_pc,
   output logic           o_d_valid
);

   lc4_pkg::word_t pc_q;

   // Redirect wins over sequential fetch
   always_ff @(posedge gwe) begin
      if (i_rst)
         pc_q <= `LC4_RESET_PC;
      else if (i_taken)
         pc_q <= i_target;
      else
         pc_q <= pc_q + 16'd1;
   end

   assign o_pc = pc_q;

   // Taken branch squashes the word fetched this cycle
   always_ff @(posedge gwe) begin
      if (i_rst || i_taken) begin
         o_d_insn  <= `LC4_NOP_INSN;
         o_d_valid <= 1'b0;
      end else begin
         o_d_insn  <= i_insn;
         o_d_valid <= 1'b1;
      end
   end

   always_ff @(posedge gwe) begin
      o_d_pc <= pc_q;
   end

endmodule

// File: lc4_branch_unit.sv
/*
 * LC4 branch unit
 * NZP register, new NZP from writeback, bypass to execute, taken decision
 */

`timescale 1ns/1ps

module lc4_branch_unit (
   input  logic           gwe,
   input  logic           i_rst,
   input  lc4_pkg::word_t i_x_insn,
   input  logic           i_x_branch,
   input  lc4_pkg::word_t i_w_data,
   input  logic           i_w_nzp_we,
   output lc4_pkg::nzp_t  o_w_nzp,
   output logic           o_taken
);

   lc4_pkg::nzp_t nzp_q;
   lc4_pkg::nzp_t nzp_cur;
   logic          neg;
   logic          zero;

   // Sign class of the value being written back
   assign neg     = i_w_data[15];
   assign zero    = (i_w_data == '0);
   assign o_w_nzp = {neg, zero, !neg && !zero};

   always_ff @(posedge gwe) begin
      if (i_rst)
         nzp_q <= 3'b000;
      else if (i_w_nzp_we)
         nzp_q <= o_w_nzp;
   end

   // Bypass when writeback updates NZP this cycle
   assign nzp_cur = i_w_nzp_we ? o_w_nzp : nzp_q;

   // BR condition bits in [11:9]
   assign o_taken = i_x_branch && ((i_x_insn[11:9] & nzp_cur) != 3'b000);

endmodule

// File: lc4_processor.sv
/*
 * LC4 five-stage pipelined core
 * Later stage registers, data memory port, writeback mux and trace port
 */

`timescale 1ns/1ps

module lc4_processor (
   input  logic           gwe,
   input  logic           i_rst,
   input  lc4_pkg::word_t i_cur_insn,
   input  lc4_pkg::word_t i_cur_dmem_data,
   output lc4_pkg::word_t o_cur_pc,
   output lc4_pkg::word_t o_dmem_addr,
   output lc4_pkg::word_t o_dmem_towrite,
   output logic           o_dmem_we,
   output logic           o_wb_valid,
   output lc4_pkg::word_t o_wb_pc,
   output lc4_pkg::word_t o_wb_insn,
   output logic           o_wb_rf_we,
   output lc4_pkg::rsel_t o_wb_rf_wsel,
   output lc4_pkg::word_t o_wb_rf_data,
   output logic           o_wb_nzp_we,
   output lc4_pkg::nzp_t  o_wb_nzp_bits
);

   // Decode stage
   lc4_pkg::word_t d_insn, d_pc, d_rs_data, d_rt_data;
   lc4_pkg::rsel_t d_r1sel, d_r2sel, d_wsel;
   logic           d_valid, d_rf_we, d_nzp_we, d_is_load, d_is_store, d_is_branch;
   // Execute stage
   lc4_pkg::word_t x_insn, x_pc, x_rs_data, x_rt_data, x_result;
   lc4_pkg::rsel_t x_wsel;
   logic           x_valid, x_rf_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
   logic           x_taken;
   // Memory stage
   lc4_pkg::word_t m_insn, m_pc, m_result, m_rt_data;
   lc4_pkg::rsel_t m_wsel;
   logic           m_valid, m_rf_we, m_nzp_we, m_is_load, m_is_store;
   // Writeback stage
   lc4_pkg::word_t w_insn, w_pc, w_result, w_load_data, w_wdata;
   lc4_pkg::rsel_t w_wsel;
   logic           w_valid, w_rf_we, w_nzp_we, w_is_load;

   // Fetch and F/D register, flushed by a taken branch
   lc4_fetch u_fetch (
      .gwe(gwe), .i_rst(i_rst), .i_taken(x_taken), .i_target(x_result),
      .i_insn(i_cur_insn), .o_pc(o_cur_pc),
      .o_d_insn(d_insn), .o_d_pc(d_pc), .o_d_valid(d_valid)
   );

   lc4_decoder u_decoder (
      .i_insn(d_insn), .o_r1sel(d_r1sel), .o_r2sel(d_r2sel), .o_wsel(d_wsel),
      .o_rf_we(d_rf_we), .o_nzp_we(d_nzp_we), .o_is_load(d_is_load),
      .o_is_store(d_is_store), .o_is_branch(d_is_branch)
   );

   // Read in decode, written from writeback
   lc4_regfile u_regfile (
      .gwe(gwe), .i_rst(i_rst), .i_rs(d_r1sel), .i_rt(d_r2sel),
      .i_rd(w_wsel), .i_wdata(w_wdata), .i_rd_we(w_rf_we),
      .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
   );

   // D/X control, enables gated by valid
   always_ff @(posedge gwe) begin
      if (i_rst || x_taken) begin
         x_valid     <= 1'b0;
         x_rf_we     <= 1'b0;
         x_nzp_we    <= 1'b0;
         x_is_load   <= 1'b0;
         x_is_store  <= 1'b0;
         x_is_branch <= 1'b0;
      end else begin
         x_valid     <= d_valid;
         x_rf_we     <= d_rf_we && d_valid;
         x_nzp_we    <= d_nzp_we && d_valid;
         x_is_load   <= d_is_load && d_valid;
         x_is_store  <= d_is_store && d_valid;
         x_is_branch <= d_is_branch && d_valid;
      end
   end

   always_ff @(posedge gwe) begin
      x_insn    <= d_insn;
      x_pc      <= d_pc;
      x_wsel    <= d_wsel;
      x_rs_data <= d_rs_data;
      x_rt_data <= d_rt_data;
   end

   lc4_alu u_alu (
      .i_insn(x_insn), .i_pc(x_pc), .i_r1data(x_rs_data), .i_r2data(x_rt_data),
      .o_result(x_result)
   );

   // Resolves BR in execute with NZP bypass from writeback
   lc4_branch_unit u_branch (
      .gwe(gwe), .i_rst(i_rst), .i_x_insn(x_insn), .i_x_branch(x_is_branch),
      .i_w_data(w_wdata), .i_w_nzp_we(w_nzp_we),
      .o_w_nzp(o_wb_nzp_bits), .o_taken(x_taken)
   );

   // X/M control
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         m_valid    <= 1'b0;
         m_rf_we    <= 1'b0;
         m_nzp_we   <= 1'b0;
         m_is_load  <= 1'b0;
         m_is_store <= 1'b0;
      end else begin
         m_valid    <= x_valid;
         m_rf_we    <= x_rf_we;
         m_nzp_we   <= x_nzp_we;
         m_is_load  <= x_is_load;
         m_is_store <= x_is_store;
      end
   end

   always_ff @(posedge gwe) begin
      m_insn    <= x_insn;
      m_pc      <= x_pc;
      m_wsel    <= x_wsel;
      m_result  <= x_result;
      m_rt_data <= x_rt_data;
   end

   // Data memory, address from the ALU, store data is Rt
   assign o_dmem_we      = m_is_store;
   assign o_dmem_addr    = (m_is_load || m_is_store) ? m_result : '0;
   assign o_dmem_towrite = m_is_store ? m_rt_data : '0;

   // M/W control
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         w_valid   <= 1'b0;
         w_rf_we   <= 1'b0;
         w_nzp_we  <= 1'b0;
         w_is_load <= 1'b0;
      end else begin
         w_valid   <= m_valid;
         w_rf_we   <= m_rf_we;
         w_nzp_we  <= m_nzp_we;
         w_is_load <= m_is_load;
      end
   end

   // Load data captured at the end of the memory cycle
   always_ff @(posedge gwe) begin
      w_insn      <= m_insn;
      w_pc        <= m_pc;
      w_wsel      <= m_wsel;
      w_result    <= m_result;
      w_load_data <= i_cur_dmem_data;
   end

   assign w_wdata = w_is_load ? w_load_data : w_result;

   // Trace of the retiring instruction
   assign o_wb_valid   = w_valid;
   assign o_wb_pc      = w_pc;
   assign o_wb_insn    = w_insn;
   assign o_wb_rf_we   = w_rf_we;
   assign o_wb_rf_wsel = w_wsel;
   assign o_wb_rf_data = w_wdata;
   assign o_wb_nzp_we  = w_nzp_we;

endmodule

// File: lc4_sva.sv
/*
 * LC4 core assertions
 * Writeback trace and data-memory enable checks, bound into the core
 */

`timescale 1ns/1ps

module lc4_sva (
   input logic          gwe,
   input logic          i_rst,
   input logic          i_wb_valid,
   input logic          i_wb_rf_we,
   input logic          i_wb_nzp_we,
   input lc4_pkg::nzp_t i_wb_nzp_bits,
   input logic          i_dmem_we
);

   // Register write only from a valid retirement
   a_rf_we_valid: assert property (@(posedge gwe) disable iff (i_rst)
      i_wb_rf_we |-> i_wb_valid)
      else $error("register write in writeback without a valid instruction");

   // NZP written back is one sign class
   a_nzp_onehot: assert property (@(posedge gwe) disable iff (i_rst)
      i_wb_nzp_we |-> $onehot(i_wb_nzp_bits))
      else $error("NZP bits written back do not have exactly one bit set");

   // Reset clears the memory stage
   a_no_store_after_reset: assert property (@(posedge gwe)
      i_rst |=> !i_dmem_we)
      else $error("data memory write enable high in the cycle after reset");

endmodule

bind lc4_processor lc4_sva u_sva (
   .gwe(gwe),
   .i_rst(i_rst),
   .i_wb_valid(o_wb_valid),
   .i_wb_rf_we(o_wb_rf_we),
   .i_wb_nzp_we(o_wb_nzp_we),
   .i_wb_nzp_bits(o_wb_nzp_bits),
   .i_dmem_we(o_dmem_we)
);

// File: lc4_tb.sv
/*
 * LC4 core testbench
 * Directed programs checked against an ISA reference model
 * Instruction and data memories modeled alongside the core
 */

`timescale 1ns/1ps

`include "lc4_consts.svh"

module lc4_tb;

   // Twice the reset and run length of all five tests
   localparam int NUM_TESTS    = 5;
   localparam int RESET_CYCLES = 10;
   localparam int TEST_CYCLES  = 30;
   localparam int MAX_CYCLES   = 2 * NUM_TESTS * (RESET_CYCLES + TEST_CYCLES);
   localparam int IMEM_DEPTH   = 64;

   logic           gwe;
   logic           i_rst;
   lc4_pkg::word_t i_cur_insn;
   lc4_pkg::word_t i_cur_dmem_data;
   lc4_pkg::word_t o_cur_pc;
   lc4_pkg::word_t o_dmem_addr;
   lc4_pkg::word_t o_dmem_towrite;
   logic           o_dmem_we;
   logic           o_wb_valid;
   lc4_pkg::word_t o_wb_pc;
   lc4_pkg::word_t o_wb_insn;
   logic           o_wb_rf_we;
   lc4_pkg::rsel_t o_wb_rf_wsel;
   lc4_pkg::word_t o_wb_rf_data;
   logic           o_wb_nzp_we;
   lc4_pkg::nzp_t  o_wb_nzp_bits;

   // Program, data memory and the model's own copy
   lc4_pkg::word_t imem [IMEM_DEPTH];
   lc4_pkg::word_t dmem [65536];
   lc4_pkg::word_t model_mem [65536];
   lc4_pkg::word_t pc_off;
   int             prog_len;
   int             cycles;

   // Predicted retirements in program order
   lc4_pkg::word_t exp_pc [$];
   lc4_pkg::word_t exp_insn [$];
   lc4_pkg::word_t exp_data [$];
   lc4_pkg::nzp_t  exp_nzp [$];
   logic           exp_rf_we [$];
   logic           exp_taken [$];
   // Predicted stores
   lc4_pkg::word_t exp_st_addr [$];
   lc4_pkg::word_t exp_st_data [$];

   lc4_processor dut (
      .gwe(gwe), .i_rst(i_rst), .i_cur_insn(i_cur_insn), .i_cur_dmem_data(i_cur_dmem_data),
      .o_cur_pc(o_cur_pc), .o_dmem_addr(o_dmem_addr), .o_dmem_towrite(o_dmem_towrite),
      .o_dmem_we(o_dmem_we), .o_wb_valid(o_wb_valid), .o_wb_pc(o_wb_pc),
      .o_wb_insn(o_wb_insn), .o_wb_rf_we(o_wb_rf_we), .o_wb_rf_wsel(o_wb_rf_wsel),
      .o_wb_rf_data(o_wb_rf_data), .o_wb_nzp_we(o_wb_nzp_we), .o_wb_nzp_bits(o_wb_nzp_bits)
   );

   always #10 gwe = ~gwe;

   // Fetch past the program end reads NOP
   assign pc_off     = o_cur_pc - `LC4_RESET_PC;
   assign i_cur_insn = (pc_off < 16'(IMEM_DEPTH)) ? imem[pc_off[5:0]] : `LC4_NOP_INSN;

   // Loads read combinationally and stores land on the rising edge
   assign i_cur_dmem_data = dmem[o_dmem_addr];

   always @(posedge gwe) begin
      if (o_dmem_we)
         dmem[o_dmem_addr] = o_dmem_towrite;
   end

   always @(posedge gwe) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES)
         report_failure($sformatf("Timeout: run still going after %0d cycles", MAX_CYCLES));
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped on failure");
   endtask

   task automatic check_eq(input string test_name, input string field,
                           input lc4_pkg::word_t expected, input lc4_pkg::word_t actual);
      if (expected !== actual)
         report_failure($sformatf("Error: %s: %s expected %h, actual %h",
                                  test_name, field, expected, actual));
   endtask

   // Byte-swapped address under a mask
   function automatic lc4_pkg::word_t fill_word(input lc4_pkg::word_t addr);
      return {addr[7:0], addr[15:8]} ^ 16'h3c5a;
   endfunction

   // ADD, SUB, AND, OR, XOR register forms
   function automatic lc4_pkg::word_t rrr_insn(input logic [3:0] opc, input logic [2:0] sub,
                                               input lc4_pkg::rsel_t rd,
                                               input lc4_pkg::rsel_t rs,
                                               input lc4_pkg::rsel_t rt);
      return {opc, rd, rs, sub, rt};
   endfunction

   function automatic lc4_pkg::word_t addi_insn(input lc4_pkg::rsel_t rd,
                                                input lc4_pkg::rsel_t rs,
                                                input logic [4:0] imm);
      return {lc4_pkg::OP_ARITH, rd, rs, 1'b1, imm};
   endfunction

   // LDR and STR with r as Rd or the store data register
   function automatic lc4_pkg::word_t mem_insn(input logic [3:0] opc, input lc4_pkg::rsel_t r,
                                               input lc4_pkg::rsel_t rs,
                                               input logic [5:0] off);
      return {opc, r, rs, off};
   endfunction

   function automatic lc4_pkg::word_t const_insn(input lc4_pkg::rsel_t rd,
                                                 input logic [8:0] imm);
      return {lc4_pkg::OP_CONST, rd, imm};
   endfunction

   function automatic lc4_pkg::word_t br_insn(input logic [2:0] cond, input logic [8:0] off);
      return {lc4_pkg::OP_BR, cond, off};
   endfunction

   task automatic clear_program();
      for (int i = 0; i < IMEM_DEPTH; i++)
         imem[i] = `LC4_NOP_INSN;
      prog_len = 0;
   endtask

   task automatic append_insn(input lc4_pkg::word_t insn);
      imem[prog_len] = insn;
      prog_len++;
   endtask

   task automatic load_data();
      for (int a = 0; a < 65536; a++) begin
         dmem[a]      = fill_word(16'(a));
         model_mem[a] = fill_word(16'(a));
      end
   endtask

   // ISA model stepping one instruction at a time in program order
   task automatic build_expected();
      lc4_pkg::word_t r [`LC4_NUM_REGS];
      lc4_pkg::nzp_t  nzp;
      lc4_pkg::word_t pc;
      lc4_pkg::word_t off;
      lc4_pkg::word_t insn;
      lc4_pkg::word_t val;
      lc4_pkg::word_t addr;
      logic           we;
      logic           taken;
      int             steps;
      exp_pc.delete();
      exp_insn.delete();
      exp_data.delete();
      exp_nzp.delete();
      exp_rf_we.delete();
      exp_taken.delete();
      exp_st_addr.delete();
      exp_st_data.delete();
      for (int i = 0; i < `LC4_NUM_REGS; i++)
         r[i] = '0;
      nzp   = 3'b000;
      pc    = `LC4_RESET_PC;
      off   = '0;
      steps = 0;
      while (int'(off) < prog_len && steps < IMEM_DEPTH) begin
         insn  = imem[off[5:0]];
         we    = 1'b0;
         taken = 1'b0;
         val   = '0;
         case (insn[15:12])
            lc4_pkg::OP_CONST: begin
               val = {{7{insn[8]}}, insn[8:0]};
               we  = 1'b1;
            end
            lc4_pkg::OP_ARITH: begin
               we = 1'b1;
               if (insn[5])
                  val = r[insn[8:6]] + {{11{insn[4]}}, insn[4:0]};
               else if (insn[5:3] == 3'b000)
                  val = r[insn[8:6]] + r[insn[2:0]];
               else if (insn[5:3] == 3'b010)
                  val = r[insn[8:6]] - r[insn[2:0]];
               else
                  we = 1'b0;
            end
            lc4_pkg::OP_LOGIC: begin
               we = 1'b1;
               case (insn[5:3])
                  3'b000:  val = r[insn[8:6]] & r[insn[2:0]];
                  3'b010:  val = r[insn[8:6]] | r[insn[2:0]];
                  3'b011:  val = r[insn[8:6]] ^ r[insn[2:0]];
                  default: we = 1'b0;
               endcase
            end
            lc4_pkg::OP_LDR: begin
               addr = r[insn[8:6]] + {{10{insn[5]}}, insn[5:0]};
               val  = model_mem[addr];
               we   = 1'b1;
            end
            lc4_pkg::OP_STR: begin
               addr            = r[insn[8:6]] + {{10{insn[5]}}, insn[5:0]};
               model_mem[addr] = r[insn[11:9]];
               exp_st_addr.push_back(addr);
               exp_st_data.push_back(r[insn[11:9]]);
            end
            lc4_pkg::OP_BR: begin
               taken = (insn[11:9] & nzp) != 3'b000;
            end
            default: begin
               // Dropped opcodes retire with no effect
               we = 1'b0;
            end
         endcase
         if (we) begin
            r[insn[11:9]] = val;
            nzp = val[15] ? 3'b100 : ((val == '0) ? 3'b010 : 3'b001);
         end
         exp_pc.push_back(pc);
         exp_insn.push_back(insn);
         exp_data.push_back(val);
         exp_nzp.push_back(nzp);
         exp_rf_we.push_back(we);
         exp_taken.push_back(taken);
         pc    = taken ? pc + 16'd1 + {{7{insn[8]}}, insn[8:0]} : pc + 16'd1;
         off   = pc - `LC4_RESET_PC;
         steps++;
      end
   endtask

   task automatic apply_reset();
      @(negedge gwe);
      i_rst = 1'b1;
      repeat (RESET_CYCLES) @(negedge gwe);
      i_rst = 1'b0;
   endtask

   task automatic start_program();
      load_data();
      build_expected();
      apply_reset();
   endtask

   // Follows the trace port until every predicted instruction has retired
   task automatic run_and_check(input string test_name);
      int idx;
      int st_idx;
      int gap;
      idx    = 0;
      st_idx = 0;
      gap    = 0;
      while (idx < exp_pc.size()) begin
         @(negedge gwe);
         // Store in the memory stage
         if (o_dmem_we) begin
            if (st_idx >= exp_st_addr.size())
               report_failure($sformatf("Store to %h in test %s that the program never makes",
                                        o_dmem_addr, test_name));
            check_eq(test_name, "store address", exp_st_addr[st_idx], o_dmem_addr);
            check_eq(test_name, "store data", exp_st_data[st_idx], o_dmem_towrite);
            st_idx++;
         end
         if (gap > 1) begin
            // Squashed slots behind a taken branch
            check_eq(test_name, "bubble after taken branch", 16'd0, 16'(o_wb_valid));
            gap--;
         end else begin
            if (gap == 1)
               check_eq(test_name, "target after two bubbles", 16'd1, 16'(o_wb_valid));
            gap = 0;
            if (o_wb_valid) begin
               check_eq(test_name, "retire pc", exp_pc[idx], o_wb_pc);
               check_eq(test_name, "retire insn", exp_insn[idx], o_wb_insn);
               check_eq(test_name, "rf we", 16'(exp_rf_we[idx]), 16'(o_wb_rf_we));
               check_eq(test_name, "nzp we", 16'(exp_rf_we[idx]), 16'(o_wb_nzp_we));
               if (exp_rf_we[idx]) begin
                  check_eq(test_name, "rf wsel", 16'(exp_insn[idx][11:9]), 16'(o_wb_rf_wsel));
                  check_eq(test_name, "rf data", exp_data[idx], o_wb_rf_data);
                  check_eq(test_name, "nzp bits", 16'(exp_nzp[idx]), 16'(o_wb_nzp_bits));
               end
               if (exp_taken[idx])
                  gap = 3;
               idx++;
            end
         end
      end
      check_eq(test_name, "store count", 16'(exp_st_addr.size()), 16'(st_idx));
   endtask

   task automatic reset_test();
      clear_program();
      append_insn(const_insn(3'd1, 9'd5));
      start_program();
      // Still at the reset PC before the first rising edge
      check_eq("reset", "pc after reset", `LC4_RESET_PC, o_cur_pc);
      for (int i = 0; i < 4; i++) begin
         check_eq("reset", "wb valid before first retire", 16'd0, 16'(o_wb_valid));
         check_eq("reset", "dmem we before first retire", 16'd0, 16'(o_dmem_we));
         @(negedge gwe);
      end
      // First fetch reaches writeback four cycles later
      check_eq("reset", "first retire valid", 16'd1, 16'(o_wb_valid));
      check_eq("reset", "first retire pc", `LC4_RESET_PC, o_wb_pc);
   endtask

   task automatic alu_test();
      clear_program();
      append_insn(const_insn(3'd1, 9'd6));
      append_insn(const_insn(3'd2, 9'h1fd));
      append_insn(const_insn(3'd0, 9'd0));
      append_insn(`LC4_NOP_INSN);
      append_insn(rrr_insn(lc4_pkg::OP_ARITH, 3'b000, 3'd3, 3'd1, 3'd2));
      append_insn(rrr_insn(lc4_pkg::OP_ARITH, 3'b010, 3'd4, 3'd1, 3'd2));
      append_insn(addi_insn(3'd5, 3'd1, 5'h19));
      append_insn(rrr_insn(lc4_pkg::OP_LOGIC, 3'b000, 3'd6, 3'd1, 3'd2));
      append_insn(rrr_insn(lc4_pkg::OP_LOGIC, 3'b010, 3'd7, 3'd1, 3'd2));
      append_insn(rrr_insn(lc4_pkg::OP_LOGIC, 3'b011, 3'd3, 3'd1, 3'd2));
      start_program();
      run_and_check("alu");
   endtask

   // Walks one register across zero
   task automatic nzp_test();
      clear_program();
      append_insn(const_insn(3'd1, 9'd1));
      append_insn(const_insn(3'd2, 9'h100));
      append_insn(`LC4_NOP_INSN);
      append_insn(addi_insn(3'd1, 3'd1, 5'h1f));
      append_insn(`LC4_NOP_INSN);
      append_insn(`LC4_NOP_INSN);
      append_insn(addi_insn(3'd1, 3'd1, 5'h1f));
      append_insn(`LC4_NOP_INSN);
      append_insn(`LC4_NOP_INSN);
      append_insn(addi_insn(3'd1, 3'd1, 5'd2));
      append_insn(rrr_insn(lc4_pkg::OP_LOGIC, 3'b011, 3'd3, 3'd2, 3'd2));
      start_program();
      run_and_check("nzp");
   endtask

   task automatic mem_test();
      clear_program();
      append_insn(const_insn(3'd1, 9'd16));
      append_insn(const_insn(3'd2, 9'h19c));
      append_insn(`LC4_NOP_INSN);
      append_insn(`LC4_NOP_INSN);
      append_insn(mem_insn(lc4_pkg::OP_STR, 3'd2, 3'd1, 6'd5));
      append_insn(mem_insn(lc4_pkg::OP_LDR, 3'd3, 3'd1, 6'd5));
      append_insn(mem_insn(lc4_pkg::OP_LDR, 3'd4, 3'd1, 6'h3f));
      append_insn(mem_insn(lc4_pkg::OP_STR, 3'd1, 3'd1, 6'd0));
      append_insn(`LC4_NOP_INSN);
      append_insn(mem_insn(lc4_pkg::OP_LDR, 3'd5, 3'd1, 6'd0));
      append_insn(rrr_insn(lc4_pkg::OP_ARITH, 3'b000, 3'd6, 3'd3, 3'd4));
      start_program();
      run_and_check("store_load");
   endtask

   // Taken on p, not taken, taken on z, taken on n
   task automatic branch_test();
      clear_program();
      append_insn(const_insn(3'd1, 9'd1));
      append_insn(`LC4_NOP_INSN);
      append_insn(br_insn(3'b001, 9'd2));
      append_insn(const_insn(3'd2, 9'd7));
      append_insn(const_insn(3'd3, 9'd7));
      append_insn(const_insn(3'd4, 9'd0));
      append_insn(`LC4_NOP_INSN);
      append_insn(br_insn(3'b100, 9'd1));
      append_insn(br_insn(3'b010, 9'd2));
      append_insn(const_insn(3'd5, 9'd9));
      append_insn(const_insn(3'd6, 9'd9));
      append_insn(addi_insn(3'd1, 3'd1, 5'h1e));
      append_insn(`LC4_NOP_INSN);
      append_insn(br_insn(3'b101, 9'd1));
      append_insn(const_insn(3'd7, 9'd3));
      append_insn(const_insn(3'd7, 9'd4));
      start_program();
      run_and_check("branch");
   endtask

   initial begin
      gwe    = 1'b0;
      i_rst  = 1'b1;
      cycles = 0;
      reset_test();
      alu_test();
      nzp_test();
      mem_test();
      branch_test();
      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: lc4.f
+incdir+.
lc4_pkg.sv
lc4_decoder.sv
lc4_alu.sv
lc4_regfile.sv
lc4_fetch.sv
lc4_branch_unit.sv
lc4_processor.sv
lc4_sva.sv
lc4_tb.sv

// File: Makefile
SIM       ?= verilator
TOP       ?= lc4_tb
FILELIST  ?= lc4.f
OBJ_DIR   ?= obj_dir
SIMFLAGS  ?= --binary --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
